// ==== hdl/sys_pkg.sv ====
package sys_pkg;

	// ====================
	// Core identity
	// ====================
	localparam logic [23:0] CORE_MAGIC = 24'h5CA623;
	localparam logic [7:0]  CORE_TYPE  = 8'hA4;
	localparam logic [1:0]  IO_VER     = 2'd1;

	// HPS command codes
	localparam logic [7:0] CMD_CFG    = 8'h01;
	localparam logic [7:0] CMD_TIMING = 8'h20;
	localparam logic [7:0] CMD_LED    = 8'h25;

	localparam int TIMING_WORDS = 8;
	localparam int TIMING_BITS  = 12;

	// ====================
	// Shared structs
	// ====================
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} io_word_t;

	typedef struct packed {
		logic     strobe;
		logic     uio;
		io_word_t din;
	} io_req_t;

	// Upper byte carries the HDMI resolution, not decoded here
	typedef struct packed {
		logic [7:0] rsv_res;
		logic       dvi_mode;
		logic       audio_96k;
		logic       ypbpr_en;
		logic       rsv_4;
		logic       csync;
		logic       vga_scaler;
		logic [1:0] rsv_lo;
	} sys_cfg_t;

	// Field order matches the order of words after CMD_TIMING
	typedef struct packed {
		logic [TIMING_BITS-1:0] width;
		logic [TIMING_BITS-1:0] hfp;
		logic [TIMING_BITS-1:0] hs;
		logic [TIMING_BITS-1:0] hbp;
		logic [TIMING_BITS-1:0] height;
		logic [TIMING_BITS-1:0] vfp;
		logic [TIMING_BITS-1:0] vs;
		logic [TIMING_BITS-1:0] vbp;
	} video_timing_t;

	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_ovr_t;

	typedef struct packed {
		logic       led_user;
		logic [1:0] led_power;
		logic [1:0] led_disk;
	} core_leds_t;

	typedef struct packed {
		logic signed [15:0] ls;
		logic signed [15:0] rs;
		logic               sgn;
		logic [1:0]         mix;
	} audio_in_t;

	typedef struct packed {
		logic [15:0] left;
		logic [15:0] right;
	} audio_out_t;

	// 1280x720@60 CEA
	localparam video_timing_t DEF_TIMING = '{
		width:  12'd1280,
		hfp:    12'd110,
		hs:     12'd40,
		hbp:    12'd220,
		height: 12'd720,
		vfp:    12'd5,
		vs:     12'd5,
		vbp:    12'd20
	};

endpackage

// ==== hdl/hps_link.sv ====
`timescale 1ns/100ps

module hps_link (
	input  logic             FPGA_CLK2_50,
	input  logic             resetd,
	input  logic [31:0]      gp_out,
	input  logic             btn_user,
	input  logic             btn_osd,
	output logic [31:0]      gp_in,
	output sys_pkg::io_req_t io_req,
	output logic             hps_disk
);
	import sys_pkg::*;

	logic [31:0] gp_outd;
	logic [31:0] gp_outr;
	logic        io_clk;
	logic        rack;
	logic        io_ack;

	// ====================
	// HPS word capture
	// ====================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			gp_outd <= '0;
			gp_outr <= '0;
		end else begin
			gp_outd <= gp_out;
			gp_outr <= gp_outd;
		end
	end

	assign io_clk = gp_outr[17];

	// Rack records the last io_clk level seen, ack lags it by a cycle
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			rack   <= 1'b0;
			io_ack <= 1'b0;
		end else begin
			rack   <= io_clk;
			io_ack <= rack;
		end
	end

	// One cycle high per io_clk toggle
	assign io_req.strobe = io_clk ^ rack;
	assign io_req.uio    = gp_outr[20];
	assign io_req.din    = gp_outr[15:0];
	assign hps_disk      = gp_outr[29];

	// ====================
	// Reply word
	// ====================
	// Magic until the HPS reports ready, status word after
	assign gp_in = gp_outr[31] ?
		{1'b0, btn_user, btn_osd, 9'd0, IO_VER, io_ack, 1'b0, 16'd0} :
		{CORE_MAGIC, CORE_TYPE};

endmodule

// ==== hdl/cmd_decoder.sv ====
`timescale 1ns/100ps

module cmd_decoder (
	input  logic                   FPGA_CLK2_50,
	input  logic                   resetd,
	input  sys_pkg::io_req_t       io_req,
	output sys_pkg::sys_cfg_t      sys_cfg,
	output logic                   cfg_got,
	output sys_pkg::video_timing_t timing,
	output sys_pkg::led_ovr_t      led_ovr
);
	import sys_pkg::*;

	localparam int CNT_BITS = 8;

	io_req_t             req_q;
	logic                old_strobe;
	logic                stb_rise;
	logic                has_cmd;
	logic [7:0]          cmd;
	logic [CNT_BITS-1:0] cnt;
	logic [TIMING_BITS-1:0] tval;

	// Request is retimed once so word and strobe stay aligned
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			req_q      <= '0;
			old_strobe <= 1'b0;
		end else begin
			req_q      <= io_req;
			old_strobe <= req_q.strobe;
		end
	end

	assign stb_rise = req_q.strobe & ~old_strobe;
	assign tval     = req_q.din[TIMING_BITS-1:0];

	// ====================
	// Frame decode
	// ====================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
			cnt     <= '0;
			sys_cfg <= '0;
			cfg_got <= 1'b0;
			timing  <= DEF_TIMING;
			led_ovr <= '0;
		end else if (!req_q.uio) begin
			has_cmd <= 1'b0;
		end else if (stb_rise) begin
			if (!has_cmd) begin
				// First word of the frame holds the command
				has_cmd <= 1'b1;
				cmd     <= req_q.din.lo;
				cnt     <= '0;
			end else begin
				case (cmd)
					CMD_CFG: begin
						sys_cfg <= sys_cfg_t'(req_q.din);
						cfg_got <= 1'b1;
					end
					CMD_TIMING: begin
						cfg_got <= 1'b0;
						if (cnt != '1)
							cnt <= cnt + 1'b1;
						// Words past the eighth are only counted
						if (cnt < TIMING_WORDS) begin
							case (cnt[2:0])
								3'd0: timing.width  <= tval;
								3'd1: timing.hfp    <= tval;
								3'd2: timing.hs     <= tval;
								3'd3: timing.hbp    <= tval;
								3'd4: timing.height <= tval;
								3'd5: timing.vfp    <= tval;
								3'd6: timing.vs     <= tval;
								default: timing.vbp <= tval;
							endcase
						end
					end
					CMD_LED: begin
						led_ovr <= led_ovr_t'(req_q.din);
					end
					// Unknown commands ignore their words
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== hdl/front_panel.sv ====
`timescale 1ns/100ps

module front_panel #(
	parameter int DEB_DIV = 100000,
	parameter int DEB_LEN = 8
) (
	input  logic                FPGA_CLK2_50,
	input  logic                resetd,
	input  logic                btn_user_pin,
	input  logic                btn_osd_pin,
	input  logic [1:0]          key,
	input  sys_pkg::core_leds_t core_leds,
	input  logic                hps_disk,
	input  sys_pkg::led_ovr_t   led_ovr,
	output logic                btn_user,
	output logic                btn_osd,
	output wire                 led_power_pin,
	output wire                 led_hdd_pin,
	output wire                 led_user_pin,
	output logic [7:0]          led
);
	import sys_pkg::*;

	localparam int DIV_BITS = $clog2(DEB_DIV + 1);

	logic [DIV_BITS-1:0] div;
	logic [1:0]          pressed;
	logic [DEB_LEN-1:0]  hist [2];
	logic [DEB_LEN-1:0]  hist_nxt [2];
	logic [1:0]          btn_q;
	logic                led_p;
	logic                led_d;
	logic                led_u;

	// ====================
	// Button debounce
	// ====================
	// Index 1 is the user button, index 0 the OSD button
	assign pressed[1] = ~(btn_user_pin & key[1]);
	assign pressed[0] = ~(btn_osd_pin & key[0]);

	always_comb begin
		for (int i = 0; i < 2; i++)
			hist_nxt[i] = {hist[i][DEB_LEN-2:0], pressed[i]};
	end

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			div   <= '0;
			hist  <= '{default: '0};
			btn_q <= '0;
		end else if (div == DIV_BITS'(DEB_DIV)) begin
			div <= '0;
			for (int i = 0; i < 2; i++) begin
				hist[i] <= hist_nxt[i];
				if (&hist_nxt[i])
					btn_q[i] <= 1'b1;
				else if (~|hist_nxt[i])
					btn_q[i] <= 1'b0;
			end
		end else begin
			div <= div + 1'b1;
		end
	end

	assign btn_user = btn_q[1];
	assign btn_osd  = btn_q[0];

	// ====================
	// LED mapping
	// ====================
	assign led_p = core_leds.led_power[1] & ~core_leds.led_power[0];
	assign led_d = core_leds.led_disk[1] ? ~core_leds.led_disk[0] :
		~(core_leds.led_disk[0] | hps_disk);
	assign led_u = ~core_leds.led_user;

	// Open drain, released when lit
	assign led_power_pin = led_p ? 1'bz : 1'b0;
	assign led_hdd_pin   = led_d ? 1'bz : 1'b0;
	assign led_user_pin  = led_u ? 1'bz : 1'b0;

	// HPS override wins bit by bit
	assign led = (led_ovr.overtake & led_ovr.state) |
		(~led_ovr.overtake & {3'b000, ~led_p, 1'b0, ~led_d, 1'b0, ~led_u});

endmodule

// ==== hdl/audio_mixer.sv ====
`timescale 1ns/100ps

module audio_mixer (
	input  logic                FPGA_CLK2_50,
	input  logic                resetd,
	input  sys_pkg::audio_in_t  audio_in,
	output sys_pkg::audio_out_t audio_out
);
	import sys_pkg::*;

	// Arithmetic shift for signed samples, logical otherwise
	function automatic logic [15:0] shr(
		input logic signed [15:0] x,
		input logic [1:0]         n,
		input logic               sgn
	);
		if (sgn)
			return x >>> n;
		else
			return x >> n;
	endfunction

	// Own channel blended with the other, sums wrap at 16 bits
	function automatic logic [15:0] mix_ch(
		input logic [15:0] own,
		input logic [15:0] oth,
		input logic [1:0]  mix,
		input logic        sgn
	);
		case (mix)
			2'd0: return own;
			2'd1: return own - shr(own, 2'd3, sgn) + shr(oth, 2'd3, sgn);
			2'd2: return own - shr(own, 2'd2, sgn) + shr(oth, 2'd2, sgn);
			default: return shr(own, 2'd1, sgn) + shr(oth, 2'd1, sgn);
		endcase
	endfunction

	// ====================
	// Output register
	// ====================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			audio_out <= '0;
		end else begin
			audio_out.left  <= mix_ch(audio_in.ls, audio_in.rs,
				audio_in.mix, audio_in.sgn);
			audio_out.right <= mix_ch(audio_in.rs, audio_in.ls,
				audio_in.mix, audio_in.sgn);
		end
	end

endmodule

// ==== hdl/sync_polarity.sv ====
`timescale 1ns/100ps

module sync_polarity #(
	parameter int SYNC_CNT_BITS = 20
) (
	input  logic FPGA_CLK2_50,
	input  logic resetd,
	input  logic sync_in,
	output logic sync_out
);

	logic                     s1;
	logic                     s2;
	logic [SYNC_CNT_BITS-1:0] cnt;
	logic [SYNC_CNT_BITS-1:0] low_len;
	logic [SYNC_CNT_BITS-1:0] high_len;
	logic                     pol;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			cnt      <= '0;
			low_len  <= '0;
			high_len <= '0;
			pol      <= 1'b0;
		end else begin
			s1 <= sync_in;
			s2 <= s1;
			// Rising edge closes a low phase, falling edge a high phase
			if (s1 & ~s2)
				low_len <= cnt;
			if (~s1 & s2)
				high_len <= cnt;
			// Phase length, held at full scale on very slow inputs
			if (s1 != s2)
				cnt <= '0;
			else if (cnt != '1)
				cnt <= cnt + 1'b1;
			pol <= high_len > low_len;
		end
	end

	// Long high phase means the pulse is active low
	assign sync_out = sync_in ^ pol;

endmodule

// ==== hdl/sys_top.sv ====
`timescale 1ns/100ps

module sys_top #(
	parameter int DEB_DIV       = 100000,
	parameter int DEB_LEN       = 8,
	parameter int SYNC_CNT_BITS = 20
) (
	input  logic                   FPGA_CLK2_50,
	input  logic                   resetd,
	input  logic [31:0]            gp_out,
	input  logic                   btn_user_pin,
	input  logic                   btn_osd_pin,
	input  logic [1:0]             key,
	input  sys_pkg::core_leds_t    core_leds,
	input  sys_pkg::audio_in_t     audio_in,
	input  logic                   vs_in,
	input  logic                   hs_in,
	output logic [31:0]            gp_in,
	output sys_pkg::sys_cfg_t      sys_cfg,
	output logic                   cfg_got,
	output sys_pkg::video_timing_t timing,
	output wire                    led_power_pin,
	output wire                    led_hdd_pin,
	output wire                    led_user_pin,
	output logic [7:0]             led,
	output sys_pkg::audio_out_t    audio_out,
	output logic                   vs,
	output logic                   hs
);
	import sys_pkg::*;

	io_req_t  io_req;
	led_ovr_t led_ovr;
	logic     hps_disk;
	logic     btn_user;
	logic     btn_osd;

	// ====================
	// HPS side
	// ====================
	hps_link hps_link (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.gp_out       (gp_out),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd),
		.gp_in        (gp_in),
		.io_req       (io_req),
		.hps_disk     (hps_disk)
	);

	cmd_decoder cmd_decoder (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.io_req       (io_req),
		.sys_cfg      (sys_cfg),
		.cfg_got      (cfg_got),
		.timing       (timing),
		.led_ovr      (led_ovr)
	);

	// ====================
	// Board I/O
	// ====================
	front_panel #(
		.DEB_DIV (DEB_DIV),
		.DEB_LEN (DEB_LEN)
	) front_panel (
		.FPGA_CLK2_50  (FPGA_CLK2_50),
		.resetd        (resetd),
		.btn_user_pin  (btn_user_pin),
		.btn_osd_pin   (btn_osd_pin),
		.key           (key),
		.core_leds     (core_leds),
		.hps_disk      (hps_disk),
		.led_ovr       (led_ovr),
		.btn_user      (btn_user),
		.btn_osd       (btn_osd),
		.led_power_pin (led_power_pin),
		.led_hdd_pin   (led_hdd_pin),
		.led_user_pin  (led_user_pin),
		.led           (led)
	);

	audio_mixer audio_mixer (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.audio_in     (audio_in),
		.audio_out    (audio_out)
	);

	// Core sync can come in either polarity
	sync_polarity #(.SYNC_CNT_BITS(SYNC_CNT_BITS)) sync_v (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.sync_in      (vs_in),
		.sync_out     (vs)
	);

	sync_polarity #(.SYNC_CNT_BITS(SYNC_CNT_BITS)) sync_h (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.sync_in      (hs_in),
		.sync_out     (hs)
	);

endmodule

// ==== dv/sys_checker.sv ====
`timescale 1ns/100ps

module sys_checker (
	input logic                   FPGA_CLK2_50,
	input logic                   resetd,
	input logic [31:0]            gp_out,
	input logic                   btn_user_pin,
	input logic                   btn_osd_pin,
	input logic [1:0]             key,
	input sys_pkg::core_leds_t    core_leds,
	input sys_pkg::audio_in_t     audio_in,
	input logic                   vs_in,
	input logic                   hs_in,
	input logic [31:0]            gp_in,
	input sys_pkg::sys_cfg_t      sys_cfg,
	input logic                   cfg_got,
	input sys_pkg::video_timing_t timing,
	input wire                    led_power_pin,
	input wire                    led_hdd_pin,
	input wire                    led_user_pin,
	input logic [7:0]             led,
	input sys_pkg::audio_out_t    audio_out,
	input logic                   vs,
	input logic                   hs
);
	import sys_pkg::*;

	// One cycle to the sampling edge and three more to the ack
	// The count includes the falling edge that first shows it
	localparam int ACK_LAT = 5;

	int n_run = 0;
	int n_err = 0;

	// Selects 1 cfg, 2 timing, 3 whole gp_in, 4 button bits of gp_in
	function automatic logic [95:0] observe(input int sel);
		case (sel)
			1: return {cfg_got, sys_cfg};
			2: return timing;
			3: return gp_in;
			default: return gp_in[30:29];
		endcase
	endfunction

	// Floor division by 2**n for signed or unsigned samples
	function automatic logic [15:0] scaled(input logic [15:0] x, input int n, input logic sgn);
		int v;
		int d;
		int q;
		d = 1 << n;
		if (sgn) begin
			v = $signed(x);
			q = v / d;
			if (v < 0 && q * d != v)
				q = q - 1;
		end else begin
			q = x / d;
		end
		return q[15:0];
	endfunction

	function automatic logic [15:0] mixed(input logic [15:0] own, input logic [15:0] oth,
		input logic [1:0] mix, input logic sgn);
		case (mix)
			2'd0: return own;
			2'd1: return own - scaled(own, 3, sgn) + scaled(oth, 3, sgn);
			2'd2: return own - scaled(own, 2, sgn) + scaled(oth, 2, sgn);
			default: return scaled(own, 1, sgn) + scaled(oth, 1, sgn);
		endcase
	endfunction

	task automatic finish_test(input string name, input logic ok);
		n_run++;
		if (!ok)
			n_err++;
		$display("%s %s", ok ? "ok  " : "FAIL", name);
	endtask

	task automatic tally(input string name, input logic [95:0] exp, input logic [95:0] act);
		if (act !== exp)
			$display("MISMATCH %s expected %0h actual %0h", name, exp, act);
		finish_test(name, act === exp);
	endtask

	// ====================
	// Checks
	// ====================
	task automatic check_port(input string name, input int sel, input logic [95:0] exp);
		tally(name, exp, observe(sel));
	endtask

	task automatic check_word(input string name, input int sel, input logic [95:0] exp,
		input int lat);
		logic ok;
		ok = 1'b1;
		if (lat != ACK_LAT) begin
			$display("MISMATCH %s ack latency expected %0d actual %0d", name, ACK_LAT, lat);
			ok = 1'b0;
		end
		if (sel != 0 && observe(sel) !== exp) begin
			$display("MISMATCH %s expected %0h actual %0h", name, exp, observe(sel));
			ok = 1'b0;
		end
		finish_test(name, ok);
	endtask

	task automatic check_leds(input string name, input logic [15:0] ovr);
		logic       lit_p;
		logic       lit_d;
		logic       lit_u;
		logic [7:0] def;
		logic [10:0] exp;
		lit_p = core_leds.led_power == 2'b10;
		if (core_leds.led_disk[1])
			lit_d = !core_leds.led_disk[0];
		else
			lit_d = !core_leds.led_disk[0] && !gp_out[29];
		lit_u = !core_leds.led_user;
		def = {3'b000, !lit_p, 1'b0, !lit_d, 1'b0, !lit_u};
		exp[10] = lit_p ? 1'bz : 1'b0;
		exp[9] = lit_d ? 1'bz : 1'b0;
		exp[8] = lit_u ? 1'bz : 1'b0;
		for (int i = 0; i < 8; i++)
			exp[i] = ovr[8 + i] ? ovr[i] : def[i];
		tally(name, exp, {led_power_pin, led_hdd_pin, led_user_pin, led});
	endtask

	task automatic check_audio(input string name);
		logic [31:0] exp;
		exp = {mixed(audio_in.ls, audio_in.rs, audio_in.mix, audio_in.sgn),
			mixed(audio_in.rs, audio_in.ls, audio_in.mix, audio_in.sgn)};
		tally(name, exp, audio_out);
	endtask

	// Outputs must be the input turned active high over one period
	task automatic check_sync(input string name, input logic low_v, input logic low_h,
		input int per, input int width);
		int hi_v;
		int hi_h;
		int bad;
		hi_v = 0;
		hi_h = 0;
		bad = 0;
		repeat (per) begin
			@(negedge FPGA_CLK2_50);
			if (vs !== (vs_in ^ low_v) || hs !== (hs_in ^ low_h))
				bad++;
			if (vs === 1'b1)
				hi_v++;
			if (hs === 1'b1)
				hi_h++;
		end
		tally(name, {32'(width), 32'(width), 32'd0}, {32'(hi_v), 32'(hi_h), 32'(bad)});
	endtask

	task automatic close();
		$display("tests run %0d, failed %0d", n_run, n_err);
	endtask

endmodule

// ==== dv/tb_sys_top.sv ====
`timescale 1ns/100ps

module tb_sys_top;
	import sys_pkg::*;

	localparam int DEB_DIV       = 4;
	localparam int DEB_LEN       = 8;
	localparam int SYNC_CNT_BITS = 12;
	localparam int HOLD          = (DEB_LEN + 2) * (DEB_DIV + 1);
	localparam int SYNC_PER      = 24;
	localparam int SYNC_W        = 4;

	// Row kinds
	localparam int K_GPIN = 0;
	localparam int K_PEEK = 1;
	localparam int K_WORD = 2;
	localparam int K_LED  = 3;
	localparam int K_BTN  = 4;
	localparam int K_AUD  = 5;
	localparam int K_SYNC = 6;

	logic          FPGA_CLK2_50;
	logic          resetd;
	logic [31:0]   gp_out;
	logic          btn_user_pin;
	logic          btn_osd_pin;
	logic [1:0]    key;
	core_leds_t    core_leds;
	audio_in_t     audio_in;
	logic          vs_in;
	logic          hs_in;
	logic [31:0]   gp_in;
	sys_cfg_t      sys_cfg;
	logic          cfg_got;
	video_timing_t timing;
	wire           led_power_pin;
	wire           led_hdd_pin;
	wire           led_user_pin;
	logic [7:0]    led;
	audio_out_t    audio_out;
	logic          vs;
	logic          hs;

	string       names[$];
	int          kinds[$];
	logic [31:0] vals[$];
	int          sels[$];
	logic [95:0] exps[$];
	logic [31:0] gp_word;
	integer      seed;
	int          cycles;
	int          limit;

	sys_top #(
		.DEB_DIV       (DEB_DIV),
		.DEB_LEN       (DEB_LEN),
		.SYNC_CNT_BITS (SYNC_CNT_BITS)
	) dut0 (.*);

	sys_checker checker0 (.*);

	initial begin
		FPGA_CLK2_50 = 1'b0;
		forever #5 FPGA_CLK2_50 = ~FPGA_CLK2_50;
	end

	always @(posedge FPGA_CLK2_50) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("test failed");
			$finish;
		end
	end

	task automatic add_row(input string n, input int k, input logic [31:0] v, input int s,
		input logic [95:0] e);
		names.push_back(n);
		kinds.push_back(k);
		vals.push_back(v);
		sels.push_back(s);
		exps.push_back(e);
	endtask

	// ====================
	// Stimulus table
	// ====================
	task automatic build_table();
		logic [15:0] tw [12];
		logic [95:0] tnew;
		tw = '{16'hF640, 16'h0030, 16'h0020, 16'h0050, 16'h0384, 16'h0003,
			16'h0006, 16'h0019, 16'h0AAA, 16'h0BBB, 16'h0CCC, 16'h0DDD};
		tnew = '0;
		for (int i = 0; i < 8; i++)
			tnew = {tnew[83:0], tw[i][11:0]};
		add_row("magic", K_GPIN, 0, 3, 32'h5CA623A4);
		add_row("def_timing", K_PEEK, 0, 2, {12'd1280, 12'd110, 12'd40, 12'd220,
			12'd720, 12'd5, 12'd5, 12'd20});
		add_row("ready", K_GPIN, 1, 3, 32'h0004_0000);
		add_row("cfg_cmd", K_WORD, {1'b1, 16'h0001}, 0, 0);
		add_row("cfg_word", K_WORD, {1'b1, 16'h12E4}, 1, {1'b1, 16'h12E4});
		add_row("cfg_idle", K_WORD, {1'b0, 16'hFFFF}, 1, {1'b1, 16'h12E4});
		add_row("tim_cmd", K_WORD, {1'b1, 16'h0020}, 0, 0);
		for (int i = 0; i < 12; i++)
			add_row($sformatf("tim_w%0d", i), K_WORD, {1'b1, tw[i]},
				(i == 0) ? 1 : (i == 7 || i == 11) ? 2 : 0,
				(i == 0) ? {1'b0, 16'h12E4} : tnew);
		add_row("tim_idle", K_WORD, {1'b0, 16'h0777}, 2, tnew);
		// LED value bits: hps_disk, user, power[1:0], disk[1:0]
		add_row("led_all_off", K_LED, 6'b1_1_00_00, 0, 0);
		add_row("led_power_on", K_LED, 6'b0_1_10_01, 0, 0);
		add_row("led_disk_forced", K_LED, 6'b1_0_11_10, 0, 0);
		add_row("led_disk_idle", K_LED, 6'b0_1_01_00, 0, 0);
		add_row("led_disk_off", K_LED, 6'b0_1_10_11, 0, 0);
		add_row("led_cmd", K_WORD, {1'b1, 16'h0025}, 0, 0);
		add_row("led_word", K_WORD, {1'b1, 16'hF05A}, 0, 0);
		add_row("led_override", K_LED, 6'b0_1_10_01, 0, 16'hF05A);
		// Button value: hold cycles, pin level, user select
		add_row("user_press", K_BTN, {16'(HOLD), 14'd0, 2'b01}, 4, 2'b10);
		add_row("user_release", K_BTN, {16'(HOLD), 14'd0, 2'b11}, 4, 2'b00);
		add_row("osd_glitch", K_BTN, {16'(DEB_DIV), 14'd0, 2'b00}, 4, 2'b00);
		add_row("osd_glitch_end", K_BTN, {16'(HOLD), 14'd0, 2'b10}, 4, 2'b00);
		add_row("osd_press", K_BTN, {16'(HOLD), 14'd0, 2'b00}, 4, 2'b01);
		add_row("osd_release", K_BTN, {16'(HOLD), 14'd0, 2'b10}, 4, 2'b00);
		for (int s = 0; s < 2; s++)
			for (int m = 0; m < 4; m++)
				add_row($sformatf("audio_s%0d_m%0d", s, m), K_AUD, s * 4 + m, 0, 0);
		add_row("sync_vlow_hhigh", K_SYNC, 2'b01, 0, 0);
		add_row("sync_vhigh_hlow", K_SYNC, 2'b10, 0, 0);
	endtask

	// Toggle io_clk and count cycles until the ack matches
	task automatic send_word(input logic [31:0] v, output int lat);
		gp_word[17] = ~gp_word[17];
		gp_word[20] = v[16];
		gp_word[15:0] = v[15:0];
		@(posedge FPGA_CLK2_50);
		gp_out <= gp_word;
		lat = 0;
		do begin
			@(negedge FPGA_CLK2_50);
			lat++;
		end while (gp_in[17] !== gp_word[17] && lat < 64);
	endtask

	task automatic run_sync(input logic low_v, input logic low_h);
		for (int p = 0; p < 3; p++)
			for (int c = 0; c < SYNC_PER; c++) begin
				@(posedge FPGA_CLK2_50);
				vs_in <= (c < SYNC_W) ^ low_v;
				hs_in <= (c < SYNC_W) ^ low_h;
			end
	endtask

	// ====================
	// Driving loop
	// ====================
	task automatic apply_row(input int i);
		int          lat;
		logic [15:0] ls;
		logic [15:0] rs;
		case (kinds[i])
			K_GPIN, K_LED: begin
				@(posedge FPGA_CLK2_50);
				if (kinds[i] == K_GPIN) begin
					gp_word[31] = vals[i][0];
				end else begin
					gp_word[29] = vals[i][5];
					core_leds <= vals[i][4:0];
				end
				gp_out <= gp_word;
				repeat (3) @(posedge FPGA_CLK2_50);
				@(negedge FPGA_CLK2_50);
				if (kinds[i] == K_GPIN)
					checker0.check_port(names[i], sels[i], exps[i]);
				else
					checker0.check_leds(names[i], exps[i][15:0]);
			end
			K_PEEK: begin
				@(negedge FPGA_CLK2_50);
				checker0.check_port(names[i], sels[i], exps[i]);
			end
			K_WORD: begin
				send_word(vals[i], lat);
				checker0.check_word(names[i], sels[i], exps[i], lat);
			end
			K_BTN: begin
				@(posedge FPGA_CLK2_50);
				if (vals[i][0])
					btn_user_pin <= vals[i][1];
				else
					btn_osd_pin <= vals[i][1];
				repeat (vals[i][31:16]) @(posedge FPGA_CLK2_50);
				@(negedge FPGA_CLK2_50);
				checker0.check_port(names[i], sels[i], exps[i]);
			end
			K_AUD: begin
				ls = $random(seed);
				rs = $random(seed);
				@(posedge FPGA_CLK2_50);
				audio_in <= {ls, rs, vals[i][2:0]};
				@(posedge FPGA_CLK2_50);
				@(negedge FPGA_CLK2_50);
				checker0.check_audio(names[i]);
			end
			default: begin
				fork
					run_sync(vals[i][0], vals[i][1]);
					begin
						repeat (2 * SYNC_PER) @(posedge FPGA_CLK2_50);
						checker0.check_sync(names[i], vals[i][0], vals[i][1], SYNC_PER, SYNC_W);
					end
				join
			end
		endcase
	endtask

	initial begin
		int n_btn;
		resetd = 1'b1;
		gp_word = '0;
		gp_out = '0;
		btn_user_pin = 1'b1;
		btn_osd_pin = 1'b1;
		key = 2'b11;
		core_leds = '0;
		audio_in = '0;
		vs_in = 1'b1;
		hs_in = 1'b0;
		seed = 32'h292a;
		cycles = 0;
		limit = 0;
		build_table();
		n_btn = 0;
		foreach (kinds[i])
			if (kinds[i] == K_BTN)
				n_btn++;
		limit = kinds.size() * 64 + n_btn * DEB_LEN * (DEB_DIV + 1) * 4 + 8 * SYNC_PER;
		repeat (5) @(posedge FPGA_CLK2_50);
		resetd <= 1'b0;
		foreach (kinds[i])
			apply_row(i);
		@(negedge FPGA_CLK2_50);
		checker0.close();
		if (checker0.n_err == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== src.f ====
hdl/sys_pkg.sv
hdl/hps_link.sv
hdl/cmd_decoder.sv
hdl/front_panel.sv
hdl/audio_mixer.sv
hdl/sync_polarity.sv
hdl/sys_top.sv
dv/sys_checker.sv
dv/tb_sys_top.sv
